// File: dv/mcpuTests.hex
// word 0: program length in words (upper half), expected store count (lower half)
// then the program image from address 0, then expected stores as address, data pairs
002F0012
200A0200 2001FFFD 340200F0  // addi r10,r0,0x200 ; addi r1,r0,-3 ; ori r2,r0,0xf0
3C031234 34645678 3085FF0F  // lui r3,0x1234 ; ori r4,r3,0x5678 ; andi r5,r4,0xff0f
2830FFFE AD410000 AD450004  // slti r16,r1,-2 ; sw r1,0(r10) ; sw r5,4(r10)
AD500008 00813020 00443822  // sw r16,8(r10) ; add r6,r4,r1 ; sub r7,r2,r4
00824024 00624825 00815826  // and r8,r4,r2 ; or r9,r3,r2 ; xor r11,r4,r1
00436027 0022682A 0041702A  // nor r12,r2,r3 ; slt r13,r1,r2 ; slt r14,r2,r1
00047902 AD460010 AD470014  // srl r15,r4,4 ; sw r6,0x10 ; sw r7,0x14
AD480018 AD49001C AD4B0020  // sw r8 ; sw r9 ; sw r11
AD4C0024 AD4D0028 AD4E002C  // sw r12 ; sw r13 ; sw r14
AD4F0030 AD440040 8D510040  // sw r15 ; sw r4,0x40 ; lw r17,0x40
AD510044 11B00001 AD42007C  // sw r17,0x44 ; beq r13,r16 taken ; marker skipped
11AE0001 AD420060 15AE0001  // beq r13,r14 not taken ; marker stored ; bne r13,r14 taken
AD42007C 15B00001 AD4F0064  // marker skipped ; bne r13,r16 not taken ; marker stored
08000029 AD42007C 0C00002D  // j 0xa4 ; marker skipped ; jal 0xb4
20000055 AD40006C 1000FFFF  // addi r0,r0,0x55 ; sw r0,0x6c ; beq r0,r0,-1 spins here
AD5F0068 03E00008           // subroutine at 0xb4: sw r31,0x68 ; jr r31
00000200 FFFFFFFD 00000204 00005608
00000208 00000001 00000210 12345675
00000214 EDCBAA78 00000218 00000070
0000021C 123400F0 00000220 EDCBA985
00000224 EDCBFF0F 00000228 00000001
0000022C 00000000 00000230 01234567
00000240 12345678 00000244 12345678
00000260 000000F0 00000264 01234567
00000268 000000A8 0000026C 00000000

// File: verilog.f
design/mipsIsaPkg.sv
design/mipsCtrlPkg.sv
design/alu.sv
design/regFile.sv
design/mcuCtrl.sv
design/mdPath.sv
design/mcpuTop.sv
dv/mcpuTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= mcpuTb
FILELIST  ?= verilog.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_MSG  ?= Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

// File: dv/mcpuTb.sv
`timescale 1ns/1ps
module mcpuTb;

  localparam int memWords  = 256;
  localparam int fileWords = 512;

  logic        clk;
  logic        rstN;
  logic        memReady;
  logic [31:0] memRdata;
  logic [31:0] memAddr;
  logic [31:0] memWdata;
  logic        memRead;
  logic        memWrite;

  logic [31:0] testData [0:fileWords-1];  // count word, program, expected pairs
  logic [31:0] mem [0:memWords-1];
  integer      seed;
  int          progWords;
  int          storeCount;
  int          storeIdx;
  int          passCount;
  int          failCount;
  int          strobeErrors;
  int          cycleCount;
  int          cycleLimit;
  logic        heldRead;
  logic        heldWrite;
  logic [31:0] heldAddr;
  logic [31:0] heldWdata;

  mcpuTop u_mcpuTop (
    .clk(clk), .rstN(rstN), .memReady(memReady), .memRdata(memRdata),
    .memAddr(memAddr), .memWdata(memWdata), .memRead(memRead), .memWrite(memWrite)
  );

  always #50 clk = ~clk;

  // read data has to be valid in the ready cycle itself
  assign memRdata = memRead ? mem[memAddr[9:2]] : 32'h0;

  function automatic logic [31:0] fileWord(input int pos);
    return testData[pos[8:0]];
  endfunction

  task automatic loadProgram();
    for (int i = 0; i < memWords; i++) begin
      if (i < progWords) begin
        mem[i[7:0]] <= fileWord(1 + i);
      end else begin
        mem[i[7:0]] <= 32'hBAD00000 | (i << 2);  // unused words carry their byte address
      end
    end
  endtask

  task automatic checkStore(input logic [31:0] addr, input logic [31:0] data);
    logic [31:0] expAddr;
    logic [31:0] expData;
    logic        good;
    expAddr = fileWord(1 + progWords + 2 * storeIdx);
    expData = fileWord(2 + progWords + 2 * storeIdx);
    good    = 1'b1;
    assert (addr === expAddr) else begin
      $display("mismatch memAddr in store %0d: expected %h, got %h",
               storeIdx, expAddr, addr);
      good = 1'b0;
    end
    assert (data === expData) else begin
      $display("mismatch memWdata in store %0d: expected %h, got %h",
               storeIdx, expData, data);
      good = 1'b0;
    end
    if (good) begin
      passCount++;
      $display("store %0d passed: [%h] <= %h", storeIdx, addr, data);
    end else begin
      failCount++;
      $display("store %0d failed", storeIdx);
    end
    storeIdx++;
  endtask

  // memory back-pressure, ready roughly every other cycle
  always @(posedge clk) begin
    memReady <= ($random(seed) % 2) != 0;
  end

  always @(posedge clk) begin
    if (rstN && memWrite && memReady) begin
      mem[memAddr[9:2]] <= memWdata;
      if (storeIdx < storeCount) begin
        checkStore(memAddr, memWdata);
      end
    end
  end

  // an access that saw no ready must come back unchanged
  always @(posedge clk) begin
    if (rstN && (heldRead || heldWrite)) begin
      assert (memRead === heldRead) else begin
        $display("mismatch memRead while waiting for ready: expected %h, got %h",
                 heldRead, memRead);
        strobeErrors++;
      end
      assert (memWrite === heldWrite) else begin
        $display("mismatch memWrite while waiting for ready: expected %h, got %h",
                 heldWrite, memWrite);
        strobeErrors++;
      end
      assert (memAddr === heldAddr) else begin
        $display("mismatch memAddr while waiting for ready: expected %h, got %h",
                 heldAddr, memAddr);
        strobeErrors++;
      end
      assert (!heldWrite || memWdata === heldWdata) else begin
        $display("mismatch memWdata while waiting for ready: expected %h, got %h",
                 heldWdata, memWdata);
        strobeErrors++;
      end
    end
    heldRead  <= rstN && memRead && !memReady;
    heldWrite <= rstN && memWrite && !memReady;
    heldAddr  <= memAddr;
    heldWdata <= memWdata;
  end

  initial begin
    clk          = 1'b0;
    rstN        <= 1'b0;
    memReady    <= 1'b0;
    seed         = 32'hd93ba818;
    storeIdx     = 0;
    passCount    = 0;
    failCount    = 0;
    strobeErrors = 0;
    cycleCount   = 0;
    $readmemh("dv/mcpuTests.hex", testData);
    progWords  = {16'h0000, testData[0][31:16]};
    storeCount = {16'h0000, testData[0][15:0]};
    cycleLimit = 200 * progWords + 100;
    loadProgram();
    repeat (4) @(posedge clk);
    rstN <= 1'b1;
    while (storeIdx < storeCount && cycleCount < cycleLimit) begin
      @(negedge clk);  // stores are taken on the rising edge
      cycleCount++;
    end
    if (storeCount == 0) begin
      $display("test data holds no expected stores");
    end else if (storeIdx < storeCount) begin
      $display("timeout: program did not produce all expected stores within %0d cycles",
               cycleLimit);
    end
    $display("%0d of %0d stores checked: %0d passed, %0d failed, %0d strobe errors",
             storeIdx, storeCount, passCount, failCount, strobeErrors);
    if (storeCount > 0 && storeIdx == storeCount &&
        failCount == 0 && strobeErrors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: design/mcpuTop.sv
`timescale 1ns/1ps
module mcpuTop (
  input  logic                         clk,
  input  logic                         rstN,
  input  logic                         memReady,
  input  logic [mipsIsaPkg::dataW-1:0] memRdata,
  output logic [mipsIsaPkg::dataW-1:0] memAddr,
  output logic [mipsIsaPkg::dataW-1:0] memWdata,
  output logic                         memRead,
  output logic                         memWrite
);

  logic [mipsIsaPkg::dataW-1:0]    inst, rDataA, rDataB, wData, opA, opB, res;
  logic [mipsIsaPkg::regAddrW-1:0] rAddrA, rAddrB, wAddr;
  logic [2:0]                      aluOp, aluOpOut;
  logic                            iOrD, irWrite, regWrite, wEn, zero, coreReady;
  logic                            pcWrite, pcWriteCond, branchEq;
  mipsCtrlPkg::regDstSel           regDst;
  mipsCtrlPkg::memToRegSel         memToReg;
  mipsCtrlPkg::aluSrcASel          aluSrcA;
  mipsCtrlPkg::aluSrcBSel          aluSrcB;
  mipsCtrlPkg::pcSrcSel            pcSource;

  // ready only holds the core back while an access is pending
  assign coreReady = memReady | ~(memRead | memWrite);

  mcuCtrl u_mcuCtrl (
    .clk(clk), .rstN(rstN), .memReady(memReady), .inst(inst),
    .memRead(memRead), .memWrite(memWrite), .iOrD(iOrD), .irWrite(irWrite),
    .regDst(regDst), .regWrite(regWrite), .memToReg(memToReg),
    .aluSrcA(aluSrcA), .aluSrcB(aluSrcB), .pcSource(pcSource),
    .pcWrite(pcWrite), .pcWriteCond(pcWriteCond), .branchEq(branchEq), .aluOp(aluOp)
  );

  mdPath u_mdPath (
    .clk(clk), .rstN(rstN), .memReady(coreReady), .memRdata(memRdata),
    .iOrD(iOrD), .irWrite(irWrite), .regDst(regDst), .regWrite(regWrite),
    .memToReg(memToReg), .aluSrcA(aluSrcA), .aluSrcB(aluSrcB), .pcSource(pcSource),
    .pcWrite(pcWrite), .pcWriteCond(pcWriteCond), .branchEq(branchEq), .aluOp(aluOp),
    .rDataA(rDataA), .rDataB(rDataB), .res(res), .zero(zero),
    .inst(inst), .memAddr(memAddr), .memWdata(memWdata),
    .rAddrA(rAddrA), .rAddrB(rAddrB), .wAddr(wAddr), .wData(wData), .wEn(wEn),
    .opA(opA), .opB(opB), .aluOpOut(aluOpOut)
  );

  alu u_alu (.opA(opA), .opB(opB), .aluOp(aluOpOut), .res(res), .zero(zero));

  regFile u_regFile (
    .clk(clk), .rstN(rstN), .wEn(wEn), .rAddrA(rAddrA), .rAddrB(rAddrB),
    .wAddr(wAddr), .wData(wData), .rDataA(rDataA), .rDataB(rDataB)
  );

endmodule

// File: design/mdPath.sv
`timescale 1ns/1ps
module mdPath (
  input  logic                               clk,
  input  logic                               rstN,
  input  logic                               memReady,
  input  logic [mipsIsaPkg::dataW-1:0]       memRdata,
  input  logic                               iOrD,
  input  logic                               irWrite,
  input  mipsCtrlPkg::regDstSel              regDst,
  input  logic                               regWrite,
  input  mipsCtrlPkg::memToRegSel            memToReg,
  input  mipsCtrlPkg::aluSrcASel             aluSrcA,
  input  mipsCtrlPkg::aluSrcBSel             aluSrcB,
  input  mipsCtrlPkg::pcSrcSel               pcSource,
  input  logic                               pcWrite,
  input  logic                               pcWriteCond,
  input  logic                               branchEq,
  input  logic [2:0]                         aluOp,
  input  logic [mipsIsaPkg::dataW-1:0]       rDataA,
  input  logic [mipsIsaPkg::dataW-1:0]       rDataB,
  input  logic [mipsIsaPkg::dataW-1:0]       res,
  input  logic                               zero,
  output logic [mipsIsaPkg::dataW-1:0]       inst,
  output logic [mipsIsaPkg::dataW-1:0]       memAddr,
  output logic [mipsIsaPkg::dataW-1:0]       memWdata,
  output logic [mipsIsaPkg::regAddrW-1:0]    rAddrA,
  output logic [mipsIsaPkg::regAddrW-1:0]    rAddrB,
  output logic [mipsIsaPkg::regAddrW-1:0]    wAddr,
  output logic [mipsIsaPkg::dataW-1:0]       wData,
  output logic                               wEn,
  output logic [mipsIsaPkg::dataW-1:0]       opA,
  output logic [mipsIsaPkg::dataW-1:0]       opB,
  output logic [2:0]                         aluOpOut
);

  logic [mipsIsaPkg::dataW-1:0] ir, mdr, aluOutReg, pc, pcNext;
  logic [mipsIsaPkg::dataW-1:0] signImm, jumpTarget;
  logic                         pcEn;

  assign inst       = ir;
  assign rAddrA     = ir[25:21];
  assign rAddrB     = ir[20:16];
  assign wEn        = regWrite;
  assign aluOpOut   = aluOp;
  assign memWdata   = rDataB;
  assign memAddr    = iOrD ? aluOutReg : pc;
  assign signImm    = {{(mipsIsaPkg::dataW-16){ir[15]}}, ir[15:0]};
  assign jumpTarget = {pc[31:28], ir[25:0], 2'b00};

  // branch taken when the compare result matches beq/bne
  assign pcEn = memReady & (pcWrite | (pcWriteCond & (zero == branchEq)));

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      ir <= '0;
      pc <= '0;
    end else begin
      if (irWrite && memReady) ir <= memRdata;
      if (pcEn) pc <= pcNext;
    end
  end

  always_ff @(posedge clk) begin
    mdr       <= memRdata;
    aluOutReg <= res;
  end

  always_comb begin
    case (regDst)
      mipsCtrlPkg::regDstRt: wAddr = ir[20:16];
      mipsCtrlPkg::regDstRd: wAddr = ir[15:11];
      mipsCtrlPkg::regDstRa: wAddr = 5'd31;
      default:               wAddr = '0;
    endcase
  end

  always_comb begin
    case (memToReg)
      mipsCtrlPkg::memToRegAluOut: wData = aluOutReg;
      mipsCtrlPkg::memToRegMdr:    wData = mdr;
      mipsCtrlPkg::memToRegLui:    wData = {ir[15:0], 16'h0000};
      default:                     wData = pc;  // link
    endcase
  end

  always_comb begin
    case (aluSrcA)
      mipsCtrlPkg::aluSrcAPc:    opA = pc;
      mipsCtrlPkg::aluSrcARegA:  opA = rDataA;
      mipsCtrlPkg::aluSrcAShamt: opA = {{(mipsIsaPkg::dataW-5){1'b0}}, ir[10:6]};
      default:                   opA = '0;
    endcase
  end

  always_comb begin
    case (aluSrcB)
      mipsCtrlPkg::aluSrcBRegB:       opB = rDataB;
      mipsCtrlPkg::aluSrcBFour:       opB = 32'd4;
      mipsCtrlPkg::aluSrcBSignImm:    opB = signImm;
      mipsCtrlPkg::aluSrcBSignImmSh2: opB = {signImm[29:0], 2'b00};
      mipsCtrlPkg::aluSrcBZeroImm:    opB = {16'h0000, ir[15:0]};
      default:                        opB = '0;
    endcase
  end

  always_comb begin
    case (pcSource)
      mipsCtrlPkg::pcSrcAluRes: pcNext = res;
      mipsCtrlPkg::pcSrcAluOut: pcNext = aluOutReg;
      mipsCtrlPkg::pcSrcJump:   pcNext = jumpTarget;
      default:                  pcNext = rDataA;  // jr
    endcase
  end

endmodule

// File: design/mcuCtrl.sv
`timescale 1ns/1ps
module mcuCtrl (
  input  logic                           clk,
  input  logic                           rstN,
  input  logic                           memReady,
  input  logic [mipsIsaPkg::dataW-1:0]   inst,
  output logic                           memRead,
  output logic                           memWrite,
  output logic                           iOrD,
  output logic                           irWrite,
  output mipsCtrlPkg::regDstSel          regDst,
  output logic                           regWrite,
  output mipsCtrlPkg::memToRegSel        memToReg,
  output mipsCtrlPkg::aluSrcASel         aluSrcA,
  output mipsCtrlPkg::aluSrcBSel         aluSrcB,
  output mipsCtrlPkg::pcSrcSel           pcSource,
  output logic                           pcWrite,
  output logic                           pcWriteCond,
  output logic                           branchEq,
  output logic [2:0]                     aluOp
);

  mipsCtrlPkg::ctrlState state, nxt;
  logic [5:0] opcode, funct;
  logic [2:0] rTypeOp, iTypeOp;
  logic       rKnown;
  logic       memDone;

  assign opcode  = inst[31:26];
  assign funct   = inst[5:0];
  assign memDone = memReady & (memRead | memWrite);  // access accepted this cycle

  always_comb begin
    rKnown  = 1'b1;
    rTypeOp = mipsIsaPkg::aluAdd;
    case (funct)
      mipsIsaPkg::fnAdd: rTypeOp = mipsIsaPkg::aluAdd;
      mipsIsaPkg::fnSub: rTypeOp = mipsIsaPkg::aluSub;
      mipsIsaPkg::fnAnd: rTypeOp = mipsIsaPkg::aluAnd;
      mipsIsaPkg::fnOr:  rTypeOp = mipsIsaPkg::aluOr;
      mipsIsaPkg::fnXor: rTypeOp = mipsIsaPkg::aluXor;
      mipsIsaPkg::fnNor: rTypeOp = mipsIsaPkg::aluNor;
      mipsIsaPkg::fnSlt: rTypeOp = mipsIsaPkg::aluSlt;
      mipsIsaPkg::fnSrl: rTypeOp = mipsIsaPkg::aluSrl;
      default:           rKnown  = 1'b0;
    endcase
  end

  always_comb begin
    case (opcode)
      mipsIsaPkg::opAndi: iTypeOp = mipsIsaPkg::aluAnd;
      mipsIsaPkg::opOri:  iTypeOp = mipsIsaPkg::aluOr;
      mipsIsaPkg::opSlti: iTypeOp = mipsIsaPkg::aluSlt;
      default:            iTypeOp = mipsIsaPkg::aluAdd;  // addi, lui
    endcase
  end

  always_comb begin
    nxt = mipsCtrlPkg::sFetch;
    case (state)
      mipsCtrlPkg::sFetch:
        nxt = memDone ? mipsCtrlPkg::sDecode : mipsCtrlPkg::sFetch;
      mipsCtrlPkg::sDecode:
        case (opcode)
          mipsIsaPkg::opRtype:
            if (funct == mipsIsaPkg::fnJr) nxt = mipsCtrlPkg::sJr;
            else if (rKnown) nxt = mipsCtrlPkg::sRExec;
          mipsIsaPkg::opAddi, mipsIsaPkg::opAndi, mipsIsaPkg::opOri,
          mipsIsaPkg::opSlti, mipsIsaPkg::opLui: nxt = mipsCtrlPkg::sIExec;
          mipsIsaPkg::opLw, mipsIsaPkg::opSw:    nxt = mipsCtrlPkg::sMemAddr;
          mipsIsaPkg::opBeq, mipsIsaPkg::opBne:  nxt = mipsCtrlPkg::sBranch;
          mipsIsaPkg::opJ:                       nxt = mipsCtrlPkg::sJump;
          mipsIsaPkg::opJal:                     nxt = mipsCtrlPkg::sJal;
          default:                               nxt = mipsCtrlPkg::sFetch;  // no-op
        endcase
      mipsCtrlPkg::sMemAddr:
        nxt = (opcode == mipsIsaPkg::opLw) ? mipsCtrlPkg::sMemRead : mipsCtrlPkg::sMemWrite;
      mipsCtrlPkg::sMemRead:
        nxt = memDone ? mipsCtrlPkg::sMemWb : mipsCtrlPkg::sMemRead;
      mipsCtrlPkg::sMemWrite:
        nxt = memDone ? mipsCtrlPkg::sFetch : mipsCtrlPkg::sMemWrite;
      mipsCtrlPkg::sRExec: nxt = mipsCtrlPkg::sRWb;
      mipsCtrlPkg::sIExec: nxt = mipsCtrlPkg::sIWb;
      default:             nxt = mipsCtrlPkg::sFetch;
    endcase
  end

  // strobes are registered from the next state so they stay clean through reset
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      state    <= mipsCtrlPkg::sFetch;
      memRead  <= 1'b0;
      memWrite <= 1'b0;
    end else begin
      state    <= nxt;
      memRead  <= (nxt == mipsCtrlPkg::sFetch) || (nxt == mipsCtrlPkg::sMemRead);
      memWrite <= (nxt == mipsCtrlPkg::sMemWrite);
    end
  end

  always_comb begin
    iOrD        = 1'b0;
    irWrite     = 1'b0;
    regDst      = mipsCtrlPkg::regDstRt;
    regWrite    = 1'b0;
    memToReg    = mipsCtrlPkg::memToRegAluOut;
    aluSrcA     = mipsCtrlPkg::aluSrcAPc;
    aluSrcB     = mipsCtrlPkg::aluSrcBFour;
    pcSource    = mipsCtrlPkg::pcSrcAluRes;
    pcWrite     = 1'b0;
    pcWriteCond = 1'b0;
    branchEq    = 1'b0;
    aluOp       = mipsIsaPkg::aluAdd;
    case (state)
      mipsCtrlPkg::sFetch: begin
        irWrite = memRead;  // nothing loads in the idle cycle after reset
        pcWrite = memRead;
      end
      mipsCtrlPkg::sDecode: aluSrcB = mipsCtrlPkg::aluSrcBSignImmSh2;  // branch target
      mipsCtrlPkg::sMemAddr, mipsCtrlPkg::sMemRead, mipsCtrlPkg::sMemWrite: begin
        iOrD    = (state != mipsCtrlPkg::sMemAddr);
        aluSrcA = mipsCtrlPkg::aluSrcARegA;  // keeps ALUOut steady while waiting
        aluSrcB = mipsCtrlPkg::aluSrcBSignImm;
      end
      mipsCtrlPkg::sMemWb: begin
        memToReg = mipsCtrlPkg::memToRegMdr;
        regWrite = 1'b1;
      end
      mipsCtrlPkg::sRExec, mipsCtrlPkg::sRWb: begin
        aluSrcA  = (funct == mipsIsaPkg::fnSrl) ? mipsCtrlPkg::aluSrcAShamt
                                                : mipsCtrlPkg::aluSrcARegA;
        aluSrcB  = mipsCtrlPkg::aluSrcBRegB;
        aluOp    = rTypeOp;
        regDst   = mipsCtrlPkg::regDstRd;
        regWrite = (state == mipsCtrlPkg::sRWb);
      end
      mipsCtrlPkg::sIExec: begin
        aluSrcA = mipsCtrlPkg::aluSrcARegA;
        aluSrcB = (opcode == mipsIsaPkg::opAndi || opcode == mipsIsaPkg::opOri)
                  ? mipsCtrlPkg::aluSrcBZeroImm : mipsCtrlPkg::aluSrcBSignImm;
        aluOp   = iTypeOp;
      end
      mipsCtrlPkg::sIWb: begin
        memToReg = (opcode == mipsIsaPkg::opLui) ? mipsCtrlPkg::memToRegLui
                                                 : mipsCtrlPkg::memToRegAluOut;
        regWrite = 1'b1;
      end
      mipsCtrlPkg::sBranch: begin
        aluSrcA     = mipsCtrlPkg::aluSrcARegA;
        aluSrcB     = mipsCtrlPkg::aluSrcBRegB;
        aluOp       = mipsIsaPkg::aluSub;
        pcSource    = mipsCtrlPkg::pcSrcAluOut;
        pcWriteCond = 1'b1;
        branchEq    = (opcode == mipsIsaPkg::opBeq);
      end
      mipsCtrlPkg::sJump, mipsCtrlPkg::sJal: begin
        pcSource = mipsCtrlPkg::pcSrcJump;
        pcWrite  = 1'b1;
        regDst   = mipsCtrlPkg::regDstRa;
        memToReg = mipsCtrlPkg::memToRegPc;  // pc already holds jal + 4
        regWrite = (state == mipsCtrlPkg::sJal);
      end
      mipsCtrlPkg::sJr: begin
        pcSource = mipsCtrlPkg::pcSrcRegA;
        pcWrite  = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

// File: design/regFile.sv
`timescale 1ns/1ps
module regFile (
  input  logic                            clk,
  input  logic                            rstN,
  input  logic                            wEn,
  input  logic [mipsIsaPkg::regAddrW-1:0] rAddrA,
  input  logic [mipsIsaPkg::regAddrW-1:0] rAddrB,
  input  logic [mipsIsaPkg::regAddrW-1:0] wAddr,
  input  logic [mipsIsaPkg::dataW-1:0]    wData,
  output logic [mipsIsaPkg::dataW-1:0]    rDataA,
  output logic [mipsIsaPkg::dataW-1:0]    rDataB
);

  logic [mipsIsaPkg::dataW-1:0] regs [0:(2**mipsIsaPkg::regAddrW)-1];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < 2**mipsIsaPkg::regAddrW; i++) regs[i] <= '0;
    end else if (wEn && wAddr != '0) begin  // r0 never written
      regs[wAddr] <= wData;
    end
  end

  assign rDataA = (rAddrA == '0) ? '0 : regs[rAddrA];
  assign rDataB = (rAddrB == '0) ? '0 : regs[rAddrB];

endmodule

// File: design/alu.sv
`timescale 1ns/1ps
module alu (
  input  logic [mipsIsaPkg::dataW-1:0] opA,
  input  logic [mipsIsaPkg::dataW-1:0] opB,
  input  logic [2:0]                   aluOp,
  output logic [mipsIsaPkg::dataW-1:0] res,
  output logic                         zero
);

  logic lessThan;

  assign lessThan = $signed(opA) < $signed(opB);

  always_comb begin
    case (aluOp)
      mipsIsaPkg::aluAnd: res = opA & opB;
      mipsIsaPkg::aluOr:  res = opA | opB;
      mipsIsaPkg::aluAdd: res = opA + opB;
      mipsIsaPkg::aluXor: res = opA ^ opB;
      mipsIsaPkg::aluNor: res = ~(opA | opB);
      mipsIsaPkg::aluSrl: res = opB >> opA[4:0];  // shift amount in A
      mipsIsaPkg::aluSub: res = opA - opB;
      mipsIsaPkg::aluSlt: res = {{(mipsIsaPkg::dataW-1){1'b0}}, lessThan};
      default:            res = '0;
    endcase
  end

  assign zero = (res == '0);

endmodule

// File: design/mipsCtrlPkg.sv
package mipsCtrlPkg;

  typedef logic [1:0] regDstSel;    // register write address
  localparam regDstSel regDstRt = 2'd0;
  localparam regDstSel regDstRd = 2'd1;
  localparam regDstSel regDstRa = 2'd2;  // r31 for jal

  typedef logic [1:0] memToRegSel;  // register write data
  localparam memToRegSel memToRegAluOut = 2'd0;
  localparam memToRegSel memToRegMdr    = 2'd1;
  localparam memToRegSel memToRegLui    = 2'd2;
  localparam memToRegSel memToRegPc     = 2'd3;

  typedef logic [1:0] aluSrcASel;
  localparam aluSrcASel aluSrcAPc    = 2'd0;
  localparam aluSrcASel aluSrcARegA  = 2'd1;
  localparam aluSrcASel aluSrcAShamt = 2'd2;

  typedef logic [2:0] aluSrcBSel;
  localparam aluSrcBSel aluSrcBRegB      = 3'd0;
  localparam aluSrcBSel aluSrcBFour      = 3'd1;
  localparam aluSrcBSel aluSrcBSignImm   = 3'd2;
  localparam aluSrcBSel aluSrcBSignImmSh2 = 3'd3;
  localparam aluSrcBSel aluSrcBZeroImm   = 3'd4;

  typedef logic [1:0] pcSrcSel;
  localparam pcSrcSel pcSrcAluRes = 2'd0;  // pc + 4 straight from the ALU
  localparam pcSrcSel pcSrcAluOut = 2'd1;  // branch target
  localparam pcSrcSel pcSrcJump   = 2'd2;
  localparam pcSrcSel pcSrcRegA   = 2'd3;

  typedef enum logic [3:0] {
    sFetch, sDecode,
    sMemAddr, sMemRead, sMemWb, sMemWrite,
    sRExec, sRWb,
    sIExec, sIWb,
    sBranch, sJump, sJal, sJr
  } ctrlState;

endpackage

// File: design/mipsIsaPkg.sv
package mipsIsaPkg;

  localparam int dataW    = 32;  // machine word
  localparam int regAddrW = 5;

  // primary opcodes, inst[31:26]
  localparam logic [5:0] opRtype = 6'h00;
  localparam logic [5:0] opJ     = 6'h02;
  localparam logic [5:0] opJal   = 6'h03;
  localparam logic [5:0] opBeq   = 6'h04;
  localparam logic [5:0] opBne   = 6'h05;
  localparam logic [5:0] opAddi  = 6'h08;
  localparam logic [5:0] opSlti  = 6'h0a;
  localparam logic [5:0] opAndi  = 6'h0c;
  localparam logic [5:0] opOri   = 6'h0d;
  localparam logic [5:0] opLui   = 6'h0f;
  localparam logic [5:0] opLw    = 6'h23;
  localparam logic [5:0] opSw    = 6'h2b;

  // funct field of R-type, inst[5:0]
  localparam logic [5:0] fnSrl = 6'h02;
  localparam logic [5:0] fnJr  = 6'h08;
  localparam logic [5:0] fnAdd = 6'h20;
  localparam logic [5:0] fnSub = 6'h22;
  localparam logic [5:0] fnAnd = 6'h24;
  localparam logic [5:0] fnOr  = 6'h25;
  localparam logic [5:0] fnXor = 6'h26;
  localparam logic [5:0] fnNor = 6'h27;
  localparam logic [5:0] fnSlt = 6'h2a;

  // ALU operation codes
  localparam logic [2:0] aluAnd = 3'd0;
  localparam logic [2:0] aluOr  = 3'd1;
  localparam logic [2:0] aluAdd = 3'd2;
  localparam logic [2:0] aluXor = 3'd3;
  localparam logic [2:0] aluNor = 3'd4;
  localparam logic [2:0] aluSrl = 3'd5;
  localparam logic [2:0] aluSub = 3'd6;
  localparam logic [2:0] aluSlt = 3'd7;

endpackage
